// File: src/proc_pkg.sv
// processor package: word types, opcode map and datapath select encodings
package proc_pkg;

    typedef logic [15:0] word_t;
    typedef logic [2:0]  reg_idx_t;

    ////////////////////
    // instruction opcodes, bits 15 to 11
    ////////////////////
    typedef enum logic [4:0] {
        OP_HALT  = 5'b00000,
        OP_NOP   = 5'b00001,
        OP_ADDI  = 5'b01000,
        OP_SUBI  = 5'b01001,
        OP_XORI  = 5'b01010,
        OP_ANDNI = 5'b01011,
        OP_ST    = 5'b10000,
        OP_LD    = 5'b10001,
        OP_LBI   = 5'b11000,
        OP_SLBI  = 5'b10010,
        OP_RTYPE = 5'b11011,
        OP_BEQZ  = 5'b01100,
        OP_BNEZ  = 5'b01101,
        OP_BLTZ  = 5'b01110,
        OP_BGEZ  = 5'b01111,
        OP_J     = 5'b00100,
        OP_JAL   = 5'b00110
    } opcode_e;

    // subtract is B minus A, and-not is A and not B
    typedef enum logic [2:0] {
        ALU_ADD, ALU_SUB, ALU_XOR, ALU_ANDN, ALU_PASSB
    } alu_op_e;

    ////////////////////
    // datapath selects
    ////////////////////
    typedef enum logic [1:0] {
        IMM5S, IMM5Z, IMM8S, IMM11S
    } imm_sel_e;

    typedef enum logic [1:0] {
        WB_MEM, WB_ALU, WB_LINK, WB_IMM
    } wb_sel_e;

    // destination field: rs 10:8, rt 7:5, rd 4:2, or fixed r7
    typedef enum logic [1:0] {
        DST_RS, DST_RT, DST_RD, DST_R7
    } dst_sel_e;

    typedef enum logic [2:0] {
        BR_NONE, BR_EQZ, BR_NEZ, BR_LTZ, BR_GEZ
    } br_cond_e;

endpackage

// File: src/control.sv
// instruction decoder: opcode and function bits to datapath control levels
`timescale 1ns/10ps

module control (
    input  logic [4:0]         i_opcode,
    input  logic [1:0]         i_func,
    output proc_pkg::alu_op_e  o_alu_op,
    output proc_pkg::imm_sel_e o_imm_sel,
    output logic               o_alu_src_imm,
    output proc_pkg::wb_sel_e  o_wb_sel,
    output proc_pkg::dst_sel_e o_dst_sel,
    output logic               o_reg_write,
    output logic               o_mem_read,
    output logic               o_mem_write,
    output proc_pkg::br_cond_e o_br_cond,
    output logic               o_jump,
    output logic               o_halt,
    output logic               o_illegal
);

    proc_pkg::opcode_e op;

    assign op = proc_pkg::opcode_e'(i_opcode);

    always_comb begin
        // safe defaults, nothing written
        o_alu_op      = proc_pkg::ALU_ADD;
        o_imm_sel     = proc_pkg::IMM5S;
        o_alu_src_imm = 1'b0;
        o_wb_sel      = proc_pkg::WB_ALU;
        o_dst_sel     = proc_pkg::DST_RT;
        o_reg_write   = 1'b0;
        o_mem_read    = 1'b0;
        o_mem_write   = 1'b0;
        o_br_cond     = proc_pkg::BR_NONE;
        o_jump        = 1'b0;
        o_halt        = 1'b0;
        o_illegal     = 1'b0;

        case (op)
            proc_pkg::OP_HALT: o_halt = 1'b1;
            proc_pkg::OP_NOP: ;

            // immediate alu ops write rt
            proc_pkg::OP_ADDI, proc_pkg::OP_SUBI,
            proc_pkg::OP_XORI, proc_pkg::OP_ANDNI: begin
                o_alu_src_imm = 1'b1;
                o_reg_write   = 1'b1;
                case (op)
                    proc_pkg::OP_SUBI:  o_alu_op = proc_pkg::ALU_SUB;
                    proc_pkg::OP_XORI:  o_alu_op = proc_pkg::ALU_XOR;
                    proc_pkg::OP_ANDNI: o_alu_op = proc_pkg::ALU_ANDN;
                    default:            o_alu_op = proc_pkg::ALU_ADD;
                endcase
                if (op == proc_pkg::OP_XORI || op == proc_pkg::OP_ANDNI) begin
                    o_imm_sel = proc_pkg::IMM5Z;
                end
            end

            proc_pkg::OP_RTYPE: begin
                o_dst_sel   = proc_pkg::DST_RD;
                o_reg_write = 1'b1;
                case (i_func)
                    2'b00:   o_alu_op = proc_pkg::ALU_ADD;
                    2'b01:   o_alu_op = proc_pkg::ALU_SUB;
                    2'b10:   o_alu_op = proc_pkg::ALU_XOR;
                    default: o_alu_op = proc_pkg::ALU_ANDN;
                endcase
            end

            // rs plus imm5 address
            proc_pkg::OP_ST: begin
                o_alu_src_imm = 1'b1;
                o_mem_write   = 1'b1;
            end
            proc_pkg::OP_LD: begin
                o_alu_src_imm = 1'b1;
                o_mem_read    = 1'b1;
                o_reg_write   = 1'b1;
                o_wb_sel      = proc_pkg::WB_MEM;
            end

            proc_pkg::OP_LBI: begin
                o_imm_sel   = proc_pkg::IMM8S;
                o_wb_sel    = proc_pkg::WB_IMM;
                o_dst_sel   = proc_pkg::DST_RS;
                o_reg_write = 1'b1;
            end
            // top level builds the shifted operand for pass-b
            proc_pkg::OP_SLBI: begin
                o_imm_sel     = proc_pkg::IMM8S;
                o_alu_src_imm = 1'b1;
                o_alu_op      = proc_pkg::ALU_PASSB;
                o_dst_sel     = proc_pkg::DST_RS;
                o_reg_write   = 1'b1;
            end

            proc_pkg::OP_BEQZ: begin
                o_imm_sel = proc_pkg::IMM8S;
                o_br_cond = proc_pkg::BR_EQZ;
            end
            proc_pkg::OP_BNEZ: begin
                o_imm_sel = proc_pkg::IMM8S;
                o_br_cond = proc_pkg::BR_NEZ;
            end
            proc_pkg::OP_BLTZ: begin
                o_imm_sel = proc_pkg::IMM8S;
                o_br_cond = proc_pkg::BR_LTZ;
            end
            proc_pkg::OP_BGEZ: begin
                o_imm_sel = proc_pkg::IMM8S;
                o_br_cond = proc_pkg::BR_GEZ;
            end

            proc_pkg::OP_J: begin
                o_imm_sel = proc_pkg::IMM11S;
                o_jump    = 1'b1;
            end
            // link into r7
            proc_pkg::OP_JAL: begin
                o_imm_sel   = proc_pkg::IMM11S;
                o_jump      = 1'b1;
                o_wb_sel    = proc_pkg::WB_LINK;
                o_dst_sel   = proc_pkg::DST_R7;
                o_reg_write = 1'b1;
            end

            default: o_illegal = 1'b1;
        endcase

        assert (!(o_illegal && o_reg_write))
        else $error("control: register write decoded for illegal opcode %h", i_opcode);
    end

endmodule

// File: src/rf.sv
// register file: eight 16-bit registers, two combinational reads, one clocked write
`timescale 1ns/10ps

module rf (
    input  logic               clk,
    input  logic               i_rst_n,
    input  proc_pkg::reg_idx_t i_rd1_sel,
    input  proc_pkg::reg_idx_t i_rd2_sel,
    input  proc_pkg::reg_idx_t i_wr_sel,
    input  logic               i_wr_en,
    input  proc_pkg::word_t    i_wr_data,
    output proc_pkg::word_t    o_rd1_data,
    output proc_pkg::word_t    o_rd2_data
);

    proc_pkg::word_t regs [8];

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int i = 0; i < 8; i++) begin
                regs[i] <= '0;
            end
        end else if (i_wr_en) begin
            regs[i_wr_sel] <= i_wr_data;
        end
    end

    // no bypass, a read in the write cycle sees the old value
    assign o_rd1_data = regs[i_rd1_sel];
    assign o_rd2_data = regs[i_rd2_sel];

    ////////////////////
    // checks
    ////////////////////
    a_wr_sel_known: assert property (
        @(posedge clk) disable iff (!i_rst_n)
        i_wr_en |-> !$isunknown(i_wr_sel)
    ) else $error("rf: write select unknown while writing");

endmodule

// File: src/alu.sv
// 16-bit alu: add, subtract, xor, and-not, pass-b, with zero and sign of operand a
`timescale 1ns/10ps

module alu (
    input  proc_pkg::word_t   i_a,
    input  proc_pkg::word_t   i_b,
    input  proc_pkg::alu_op_e i_op,
    output proc_pkg::word_t   o_out,
    output logic              o_zero,
    output logic              o_neg
);

    always_comb begin
        case (i_op)
            proc_pkg::ALU_ADD:   o_out = i_a + i_b;
            // b minus a, so subi gives imm - rs
            proc_pkg::ALU_SUB:   o_out = i_b - i_a;
            proc_pkg::ALU_XOR:   o_out = i_a ^ i_b;
            proc_pkg::ALU_ANDN:  o_out = i_a & ~i_b;
            proc_pkg::ALU_PASSB: o_out = i_b;
            default:             o_out = i_a + i_b;
        endcase
    end

    // branch tests look at rs, which sits on operand a
    assign o_zero = (i_a == '0);
    assign o_neg  = i_a[15];

endmodule

// File: src/memory.sv
// word memory: asynchronous read, clocked write, byte address with bit 0 ignored
`timescale 1ns/10ps

module memory #(
    parameter int ADDR_W = 8
) (
    input  logic            clk,
    input  proc_pkg::word_t i_addr,
    input  logic            i_wr_en,
    input  proc_pkg::word_t i_wr_data,
    output proc_pkg::word_t o_rd_data
);

    proc_pkg::word_t mem [2**ADDR_W];
    logic [ADDR_W-1:0] word_addr;

    // word index, upper address bits wrap
    assign word_addr = i_addr[ADDR_W:1];

    initial begin
        for (int i = 0; i < 2**ADDR_W; i++) begin
            mem[i] = '0;
        end
    end

    always @(posedge clk) begin
        if (i_wr_en) begin
            mem[word_addr] <= i_wr_data;
        end
    end

    assign o_rd_data = mem[word_addr];

    ////////////////////
    // checks
    ////////////////////
    a_addr_known: assert property (
        @(posedge clk) i_wr_en |-> !$isunknown(i_addr)
    ) else $error("memory: address unknown while writing");

endmodule

// File: src/proc.sv
// single-cycle 16-bit processor: fetch, decode, execute, memory and write-back in one cycle
`timescale 1ns/10ps

module proc #(
    parameter int MEM_AW = 8
) (
    input  logic               clk,
    input  logic               i_rst_n,
    input  logic               i_run,
    input  logic               i_load_en,
    input  proc_pkg::word_t    i_load_addr,
    input  proc_pkg::word_t    i_load_data,
    output logic               o_halt,
    output logic               o_err,
    output logic               o_wb_en,
    output proc_pkg::reg_idx_t o_wb_reg,
    output proc_pkg::word_t    o_wb_data,
    output proc_pkg::word_t    o_pc
);

    ////////////////////
    // signals
    ////////////////////
    proc_pkg::word_t    pc;
    proc_pkg::word_t    pc_plus2;
    proc_pkg::word_t    target;
    proc_pkg::word_t    instr;
    proc_pkg::word_t    imem_addr;
    logic               imem_wr_en;

    proc_pkg::alu_op_e  ctl_alu_op;
    proc_pkg::imm_sel_e ctl_imm_sel;
    logic               ctl_alu_src_imm;
    proc_pkg::wb_sel_e  ctl_wb_sel;
    proc_pkg::dst_sel_e ctl_dst_sel;
    logic               ctl_reg_write;
    logic               ctl_mem_read;
    logic               ctl_mem_write;
    proc_pkg::br_cond_e ctl_br_cond;
    logic               ctl_jump;
    logic               ctl_halt;
    logic               ctl_illegal;

    proc_pkg::word_t    rd1_data;
    proc_pkg::word_t    rd2_data;
    proc_pkg::word_t    imm;
    proc_pkg::word_t    alu_b;
    proc_pkg::word_t    alu_out;
    logic               alu_zero;
    logic               alu_neg;
    proc_pkg::word_t    dmem_rd_data;
    proc_pkg::word_t    load_data;

    logic               exec;
    logic               arch_ok;
    logic               br_taken;

    // an instruction executes only when running and not halted
    assign exec    = i_run && !o_halt;
    assign arch_ok = exec && !ctl_illegal;

    ////////////////////
    // fetch
    ////////////////////
    // load port owns the instruction memory while stopped
    assign imem_addr  = i_run ? pc : i_load_addr;
    assign imem_wr_en = i_load_en && !i_run;

    memory #(.ADDR_W(MEM_AW)) inst_mem (
        .clk       (clk),
        .i_addr    (imem_addr),
        .i_wr_en   (imem_wr_en),
        .i_wr_data (i_load_data),
        .o_rd_data (instr)
    );

    control u_control (
        .i_opcode      (instr[15:11]),
        .i_func        (instr[1:0]),
        .o_alu_op      (ctl_alu_op),
        .o_imm_sel     (ctl_imm_sel),
        .o_alu_src_imm (ctl_alu_src_imm),
        .o_wb_sel      (ctl_wb_sel),
        .o_dst_sel     (ctl_dst_sel),
        .o_reg_write   (ctl_reg_write),
        .o_mem_read    (ctl_mem_read),
        .o_mem_write   (ctl_mem_write),
        .o_br_cond     (ctl_br_cond),
        .o_jump        (ctl_jump),
        .o_halt        (ctl_halt),
        .o_illegal     (ctl_illegal)
    );

    // immediate extension
    always_comb begin
        case (ctl_imm_sel)
            proc_pkg::IMM5S: imm = {{11{instr[4]}}, instr[4:0]};
            proc_pkg::IMM5Z: imm = {11'b0, instr[4:0]};
            proc_pkg::IMM8S: imm = {{8{instr[7]}}, instr[7:0]};
            default:         imm = {{5{instr[10]}}, instr[10:0]};
        endcase
    end

    rf u_rf (
        .clk        (clk),
        .i_rst_n    (i_rst_n),
        .i_rd1_sel  (instr[10:8]),
        .i_rd2_sel  (instr[7:5]),
        .i_wr_sel   (o_wb_reg),
        .i_wr_en    (o_wb_en),
        .i_wr_data  (o_wb_data),
        .o_rd1_data (rd1_data),
        .o_rd2_data (rd2_data)
    );

    ////////////////////
    // execute and memory
    ////////////////////
    // slbi: rs shifted up a byte, low byte from the instruction
    always_comb begin
        if (!ctl_alu_src_imm) begin
            alu_b = rd2_data;
        end else if (ctl_alu_op == proc_pkg::ALU_PASSB) begin
            alu_b = {rd1_data[7:0], imm[7:0]};
        end else begin
            alu_b = imm;
        end
    end

    alu u_alu (
        .i_a    (rd1_data),
        .i_b    (alu_b),
        .i_op   (ctl_alu_op),
        .o_out  (alu_out),
        .o_zero (alu_zero),
        .o_neg  (alu_neg)
    );

    memory #(.ADDR_W(MEM_AW)) data_mem (
        .clk       (clk),
        .i_addr    (alu_out),
        .i_wr_en   (ctl_mem_write && arch_ok),
        .i_wr_data (rd2_data),
        .o_rd_data (dmem_rd_data)
    );

    assign load_data = ctl_mem_read ? dmem_rd_data : '0;

    ////////////////////
    // write-back
    ////////////////////
    always_comb begin
        case (ctl_dst_sel)
            proc_pkg::DST_RS: o_wb_reg = instr[10:8];
            proc_pkg::DST_RT: o_wb_reg = instr[7:5];
            proc_pkg::DST_RD: o_wb_reg = instr[4:2];
            default:          o_wb_reg = 3'd7;
        endcase
    end

    always_comb begin
        case (ctl_wb_sel)
            proc_pkg::WB_MEM:  o_wb_data = load_data;
            proc_pkg::WB_ALU:  o_wb_data = alu_out;
            proc_pkg::WB_LINK: o_wb_data = pc_plus2;
            default:           o_wb_data = imm;
        endcase
    end

    assign o_wb_en = ctl_reg_write && arch_ok;

    ////////////////////
    // next pc
    ////////////////////
    always_comb begin
        case (ctl_br_cond)
            proc_pkg::BR_EQZ: br_taken = alu_zero;
            proc_pkg::BR_NEZ: br_taken = !alu_zero;
            proc_pkg::BR_LTZ: br_taken = alu_neg;
            proc_pkg::BR_GEZ: br_taken = !alu_neg;
            default:          br_taken = 1'b0;
        endcase
    end

    assign pc_plus2 = pc + 16'd2;
    // branches and jumps are both relative to pc + 2
    assign target   = pc_plus2 + imm;

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            pc     <= '0;
            o_halt <= 1'b0;
            o_err  <= 1'b0;
        end else if (exec) begin
            if (ctl_halt || ctl_illegal) begin
                o_halt <= 1'b1;
                o_err  <= ctl_illegal;
            end else begin
                pc <= (ctl_jump || br_taken) ? target : pc_plus2;
            end
        end
    end

    assign o_pc = pc;

    ////////////////////
    // checks
    ////////////////////
    a_pc_frozen: assert property (
        @(posedge clk) disable iff (!i_rst_n)
        o_halt |=> $stable(pc)
    ) else $error("proc: pc moved while halted");

endmodule

// File: verification/proc_tb.sv
// testbench for the single-cycle processor: random programs checked against an ISA model
`timescale 1ns/10ps

module proc_tb;

    localparam int MEM_AW    = 8;
    localparam int MEM_WORDS = 2**MEM_AW;
    localparam int TIMEOUT   = 2000;
    localparam int NUM_PROGS = 28;

    logic               clk;
    logic               i_rst_n;
    logic               i_run;
    logic               i_load_en;
    proc_pkg::word_t    i_load_addr;
    proc_pkg::word_t    i_load_data;
    logic               o_halt;
    logic               o_err;
    logic               o_wb_en;
    proc_pkg::reg_idx_t o_wb_reg;
    proc_pkg::word_t    o_wb_data;
    proc_pkg::word_t    o_pc;

    int seed;

    // program image and reference state
    proc_pkg::word_t    prog [MEM_WORDS];
    proc_pkg::word_t    m_regs [8];
    proc_pkg::word_t    m_dmem [MEM_WORDS];
    proc_pkg::reg_idx_t exp_reg_q [$];
    proc_pkg::word_t    exp_data_q [$];
    proc_pkg::word_t    exp_final_pc;
    logic               exp_err;

    proc #(.MEM_AW(MEM_AW)) i_proc (
        .clk         (clk),
        .i_rst_n     (i_rst_n),
        .i_run       (i_run),
        .i_load_en   (i_load_en),
        .i_load_addr (i_load_addr),
        .i_load_data (i_load_data),
        .o_halt      (o_halt),
        .o_err       (o_err),
        .o_wb_en     (o_wb_en),
        .o_wb_reg    (o_wb_reg),
        .o_wb_data   (o_wb_data),
        .o_pc        (o_pc)
    );

    always #20 clk = ~clk;

    ////////////////////
    // failure reporting
    ////////////////////
    task automatic abort_run();
        $display("SIMULATION FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic report_mismatch(input string name, input proc_pkg::word_t got,
                                   input proc_pkg::word_t want);
        $display("FAIL %s: got %h, expected %h", name, got, want);
        abort_run();
    endtask

    task automatic report_problem(input string msg);
        $display("ERROR: %s", msg);
        abort_run();
    endtask

    function automatic int rand_below(input int k);
        return int'($unsigned($random(seed)) % k);
    endfunction

    ////////////////////
    // program generation
    ////////////////////
    function automatic proc_pkg::word_t encode_imm5(input logic [4:0] op,
            input proc_pkg::reg_idx_t rs, input proc_pkg::reg_idx_t rt, input logic [4:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic proc_pkg::word_t encode_imm8(input logic [4:0] op,
            input proc_pkg::reg_idx_t rs, input logic [7:0] imm);
        return {op, rs, imm};
    endfunction

    task automatic gen_program(input int n, input bit with_err);
        logic [4:0]         bad_ops [5];
        logic [4:0]         br_ops [4];
        proc_pkg::reg_idx_t ra;
        proc_pkg::reg_idx_t rb;
        proc_pkg::reg_idx_t rc;
        int                 i;
        int                 kind;
        int                 skip;
        bad_ops = '{5'b00010, 5'b00011, 5'b00101, 5'b00111, 5'b11111};
        br_ops  = '{proc_pkg::OP_BEQZ, proc_pkg::OP_BNEZ, proc_pkg::OP_BLTZ, proc_pkg::OP_BGEZ};
        i = 0;
        while (i < n) begin
            ra   = 3'(rand_below(8));
            rb   = 3'(rand_below(8));
            rc   = 3'(rand_below(8));
            kind = rand_below(13);
            // forward skip that lands no further than the closing slot
            skip = (n - i - 1 > 0) ? 1 + rand_below(n - i - 1) : 0;
            prog[i] = {proc_pkg::OP_NOP, 11'(rand_below(2048))};
            case (kind)
                0: prog[i] = encode_imm5(proc_pkg::OP_ADDI, ra, rb, 5'(rand_below(32)));
                1: prog[i] = encode_imm5(proc_pkg::OP_SUBI, ra, rb, 5'(rand_below(32)));
                2: prog[i] = encode_imm5(proc_pkg::OP_XORI, ra, rb, 5'(rand_below(32)));
                3: prog[i] = encode_imm5(proc_pkg::OP_ANDNI, ra, rb, 5'(rand_below(32)));
                4, 5: prog[i] = {proc_pkg::OP_RTYPE, ra, rb, rc, 2'(rand_below(4))};
                6: prog[i] = encode_imm8(proc_pkg::OP_LBI, ra, 8'(rand_below(256)));
                7: prog[i] = encode_imm8(proc_pkg::OP_SLBI, ra, 8'(rand_below(256)));
                8, 9: begin
                    // base into a small window, then the access
                    if (skip > 0) begin
                        prog[i] = encode_imm8(proc_pkg::OP_LBI, ra, 8'(16 + 2 * rand_below(8)));
                        i++;
                        prog[i] = encode_imm5((kind == 8) ? proc_pkg::OP_ST : proc_pkg::OP_LD,
                                              ra, rb, 5'(2 * rand_below(9) - 8));
                    end
                end
                10: begin
                    if (skip > 0) begin
                        prog[i] = encode_imm8(br_ops[rand_below(4)], ra, 8'(2 * skip));
                    end
                end
                11: begin
                    if (skip > 0) begin
                        prog[i] = {(rand_below(2) == 0) ? proc_pkg::OP_J : proc_pkg::OP_JAL,
                                   11'(2 * skip)};
                    end
                end
                default: ;
            endcase
            i++;
        end
        if (with_err) begin
            prog[n] = {bad_ops[rand_below(5)], 11'(rand_below(2048))};
        end else begin
            prog[n] = {proc_pkg::OP_HALT, 11'(rand_below(2048))};
        end
        // must never execute
        prog[n + 1] = encode_imm8(proc_pkg::OP_LBI, 3'd1, 8'h55);
        prog[n + 2] = {proc_pkg::OP_HALT, 11'b0};
    endtask

    ////////////////////
    // instruction-set model
    ////////////////////
    task automatic expect_write(input proc_pkg::reg_idx_t r, input proc_pkg::word_t d);
        m_regs[r] = d;
        exp_reg_q.push_back(r);
        exp_data_q.push_back(d);
    endtask

    task automatic run_model();
        proc_pkg::word_t pc;
        proc_pkg::word_t ins;
        proc_pkg::word_t rs_v;
        proc_pkg::word_t rt_v;
        proc_pkg::word_t simm5;
        proc_pkg::word_t zimm5;
        proc_pkg::word_t simm8;
        proc_pkg::word_t simm11;
        proc_pkg::word_t addr;
        proc_pkg::word_t next_pc;
        logic            taken;
        bit              done;
        int              steps;
        int              r;
        for (r = 0; r < 8; r++) begin
            m_regs[r] = '0;
        end
        exp_reg_q.delete();
        exp_data_q.delete();
        exp_err = 1'b0;
        pc      = '0;
        done    = 1'b0;
        steps   = 0;
        while (!done && steps < TIMEOUT) begin
            ins     = prog[pc[MEM_AW:1]];
            rs_v    = m_regs[ins[10:8]];
            rt_v    = m_regs[ins[7:5]];
            simm5   = {{11{ins[4]}}, ins[4:0]};
            zimm5   = {11'b0, ins[4:0]};
            simm8   = {{8{ins[7]}}, ins[7:0]};
            simm11  = {{5{ins[10]}}, ins[10:0]};
            addr    = rs_v + simm5;
            next_pc = pc + 16'd2;
            taken   = 1'b0;
            case (ins[15:11])
                proc_pkg::OP_HALT:  done = 1'b1;
                proc_pkg::OP_NOP:   ;
                proc_pkg::OP_ADDI:  expect_write(ins[7:5], rs_v + simm5);
                proc_pkg::OP_SUBI:  expect_write(ins[7:5], simm5 - rs_v);
                proc_pkg::OP_XORI:  expect_write(ins[7:5], rs_v ^ zimm5);
                proc_pkg::OP_ANDNI: expect_write(ins[7:5], rs_v & ~zimm5);
                proc_pkg::OP_RTYPE: begin
                    case (ins[1:0])
                        2'b00:   expect_write(ins[4:2], rs_v + rt_v);
                        2'b01:   expect_write(ins[4:2], rt_v - rs_v);
                        2'b10:   expect_write(ins[4:2], rs_v ^ rt_v);
                        default: expect_write(ins[4:2], rs_v & ~rt_v);
                    endcase
                end
                proc_pkg::OP_ST:    m_dmem[addr[MEM_AW:1]] = rt_v;
                proc_pkg::OP_LD:    expect_write(ins[7:5], m_dmem[addr[MEM_AW:1]]);
                proc_pkg::OP_LBI:   expect_write(ins[10:8], simm8);
                proc_pkg::OP_SLBI:  expect_write(ins[10:8], (rs_v << 8) | {8'h00, ins[7:0]});
                proc_pkg::OP_BEQZ:  taken = (rs_v == 16'h0000);
                proc_pkg::OP_BNEZ:  taken = (rs_v != 16'h0000);
                proc_pkg::OP_BLTZ:  taken = rs_v[15];
                proc_pkg::OP_BGEZ:  taken = !rs_v[15];
                proc_pkg::OP_J:     next_pc = pc + 16'd2 + simm11;
                proc_pkg::OP_JAL: begin
                    expect_write(3'd7, pc + 16'd2);
                    next_pc = pc + 16'd2 + simm11;
                end
                default: begin
                    exp_err = 1'b1;
                    done    = 1'b1;
                end
            endcase
            if (taken) begin
                next_pc = pc + 16'd2 + simm8;
            end
            if (!done) begin
                pc = next_pc;
            end
            steps++;
        end
        assert (done) else report_problem("reference model never reached the end of the program");
        exp_final_pc = pc;
    endtask

    ////////////////////
    // DUT sequencing
    ////////////////////
    task automatic reset_dut();
        @(negedge clk);
        i_rst_n   = 1'b0;
        i_run     = 1'b0;
        i_load_en = 1'b0;
        repeat (10) @(negedge clk);
        i_rst_n = 1'b1;
        #5;
        assert (o_halt == 1'b0) else report_mismatch("o_halt", 16'(o_halt), 16'h0000);
        assert (o_err == 1'b0) else report_mismatch("o_err", 16'(o_err), 16'h0000);
        assert (o_wb_en == 1'b0) else report_mismatch("o_wb_en", 16'(o_wb_en), 16'h0000);
        assert (o_pc == 16'h0000) else report_mismatch("o_pc", o_pc, 16'h0000);
    endtask

    task automatic load_program(input int words);
        int k;
        for (k = 0; k < words; k++) begin
            @(negedge clk);
            i_load_en   = 1'b1;
            i_load_addr = 16'(2 * k);
            i_load_data = prog[k];
        end
        @(negedge clk);
        i_load_en = 1'b0;
    endtask

    task automatic check_wb();
        proc_pkg::reg_idx_t want_reg;
        proc_pkg::word_t    want_data;
        if (o_wb_en) begin
            assert (exp_reg_q.size() > 0)
            else report_problem("register write beyond the expected sequence");
            want_reg  = exp_reg_q.pop_front();
            want_data = exp_data_q.pop_front();
            assert (o_wb_reg == want_reg)
            else report_mismatch("o_wb_reg", 16'(o_wb_reg), 16'(want_reg));
            assert (o_wb_data == want_data)
            else report_mismatch("o_wb_data", o_wb_data, want_data);
        end
    endtask

    task automatic run_program(input int words, input int prog_no);
        int              cycles;
        int              writes;
        bit              halted;
        proc_pkg::word_t held_pc;
        reset_dut();
        load_program(words);
        run_model();
        writes = exp_reg_q.size();
        @(negedge clk);
        i_run  = 1'b1;
        cycles = 0;
        halted = 1'b0;
        while (!halted) begin
            // sampled mid low phase, well clear of both edges
            #5;
            if (o_halt) begin
                halted = 1'b1;
            end else begin
                check_wb();
                cycles++;
                assert (cycles < TIMEOUT)
                else report_problem("processor did not halt within 2000 cycles");
                @(negedge clk);
            end
        end
        assert (o_err == exp_err) else report_mismatch("o_err", 16'(o_err), 16'(exp_err));
        assert (o_pc == exp_final_pc) else report_mismatch("o_pc", o_pc, exp_final_pc);
        assert (exp_reg_q.size() == 0)
        else report_problem("halted before all expected register writes");
        held_pc = o_pc;
        repeat (50) begin
            @(negedge clk);
            #5;
            assert (o_halt == 1'b1) else report_problem("o_halt dropped without a reset");
            assert (o_err == exp_err) else report_mismatch("o_err", 16'(o_err), 16'(exp_err));
            assert (o_wb_en == 1'b0) else report_problem("register write seen after halt");
            assert (o_pc == held_pc) else report_mismatch("o_pc", o_pc, held_pc);
        end
        @(negedge clk);
        i_run = 1'b0;
        $display("program %0d: %0d words, %0d writes, err %0b", prog_no, words, writes, exp_err);
    endtask

    initial begin
        int p;
        int n;
        bit with_err;
        clk         = 1'b0;
        i_rst_n     = 1'b0;
        i_run       = 1'b0;
        i_load_en   = 1'b0;
        i_load_addr = '0;
        i_load_data = '0;
        seed        = 15;
        // data memory starts cleared and keeps its contents across resets
        for (p = 0; p < MEM_WORDS; p++) begin
            m_dmem[p] = '0;
        end
        for (p = 0; p < NUM_PROGS; p++) begin
            with_err = (p % 7 == 6);
            n = 8 + rand_below(53);
            gen_program(n, with_err);
            run_program(n + 3, p);
        end
        reset_dut();
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

// File: vlog.f
src/proc_pkg.sv
src/control.sv
src/rf.sv
src/alu.sv
src/memory.sv
src/proc.sv
verification/proc_tb.sv

// File: Makefile
# Verilator build and run of the processor testbench

SIM_LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -j 0 -f vlog.f --top-module proc_tb -o proc_tb_sim
	./obj_dir/proc_tb_sim | tee $(SIM_LOG)
	grep -q "SIMULATION PASSED" $(SIM_LOG)

clean:
	rm -rf obj_dir $(SIM_LOG)
